// ==== build.f ====
design/disp_pkg.sv
design/wb_cfg_regs.sv
design/line_timer.sv
design/stream_ctrl_fsm.sv
design/pixel_format_conv.sv
design/disp_codec_top.sv
bench/tb_disp_codec.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the display codec testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module tb_disp_codec \
    -o sim_disp_codec

out=$(./obj_dir/sim_disp_codec)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi

// ==== bench/tb_disp_codec.sv ====
// Testbench for the display codec with Wishbone tasks, LFSR stimulus, table and scoreboard
`timescale 1ns/1ps

module tb_disp_codec;
    import disp_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_TABLE    = 10;
    localparam int N_LINE_PIX = 20;   // Random pixels for the line timing test
    localparam int N_MIX_PIX  = 30;   // Random pixels with format rewrites
    localparam int DIS_CYCLES = 40;   // Source cycles in the disable test
    localparam int LINE_LEN   = 5;
    localparam int BLANK_LEN  = 3;
    localparam int WATCHDOG_CYCLES =
        N_TABLE * 40 + (N_LINE_PIX + N_MIX_PIX + DIS_CYCLES) * 4 + 2000;

    logic        gated_clk;
    logic        rst_n;
    logic        wb_cyc, wb_stb, wb_we;
    wb_addr_t    wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r;
    logic        wb_ack;
    logic        pix_valid, pix_ready;
    logic [31:0] pix_data;
    logic        out_valid, out_line_end;
    logic [15:0] out_data;

    // Format, input word, expected output
    logic [49:0] stim_table [N_TABLE] = '{
        {FMT_RGB,  32'hFF80_4000, 16'hFC08},
        {FMT_RGB,  32'h1234_5678, 16'h11AA},
        {FMT_RGB,  32'hFFFF_FFFF, 16'hFFFF},
        {FMT_RGB,  32'h0807_0600, 16'h0820},
        {FMT_YUV,  32'h8040_C0AA, 16'h8040},
        {FMT_YUV,  32'h1234_5678, 16'h1234},
        {FMT_MONO, 32'h8000_0000, 16'hFFFF},
        {FMT_MONO, 32'h7FFF_FFFF, 16'h0000},
        {FMT_RAW,  32'hDEAD_BEEF, 16'hDEAD},
        {FMT_RAW,  32'h0001_FFFF, 16'h0001}
    };

    logic [31:0] lfsr_q = 32'd82902;
    logic [16:0] exp_q [$];            // {line_end, data}
    fmt_t        model_fmt  = FMT_RGB;
    logic [11:0] model_len  = '0;
    int          line_pos   = 0;
    int          lines_done = 0;
    int          n_accepted = 0;
    int          n_out      = 0;
    int          n_val_err  = 0;
    int          n_other_err = 0;
    logic        after_last;
    int          low_run;
    logic [31:0] rd;

    disp_codec_top dut0 (
        .gated_clk (gated_clk), .rst_n (rst_n),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .pix_valid (pix_valid), .pix_data (pix_data),
        .wb_dat_r (wb_dat_r), .wb_ack (wb_ack), .pix_ready (pix_ready),
        .out_valid (out_valid), .out_data (out_data), .out_line_end (out_line_end)
    );

    initial begin
        gated_clk = 1'b0;
        forever #(CLK_PERIOD / 2) gated_clk = ~gated_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

    // Taps for x^32 + x^22 + x^2 + x + 1 with one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // Expected display word for one pixel
    function automatic logic [15:0] conv_ref(input fmt_t f, input logic [31:0] d);
        case (f)
            FMT_RGB:  return {d[31:27], d[23:18], d[15:11]};
            FMT_MONO: return {16{d[31]}};
            default:  return d[31:16];
        endcase
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        n_val_err++;
        $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge gated_clk);
        #2;
    endtask

    // One classic cycle with stb held two extra cycles to see ack stay low
    task automatic wb_cycle(input logic we, input wb_addr_t adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        int waits;
        waits    = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(posedge gated_clk);
            #2;
            waits++;
        end while (!wb_ack && waits < 20);
        if (!wb_ack || waits != 1) begin
            n_other_err++;
            $display("wb_ack came after %0d cycles at %0t instead of 1", waits, $time);
        end
        rdat = wb_dat_r;
        if (we && adr == REG_CTRL) model_fmt = wdat[2:1];
        if (we && adr == REG_LINE_LEN) model_len = wdat[11:0];
        repeat (2) begin
            @(posedge gated_clk);
            #2;
            if (wb_ack) begin
                n_other_err++;
                $display("wb_ack high again while stb stayed high at %0t", $time);
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wait_cycles(1);
    endtask

    task automatic wb_write(input wb_addr_t adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output logic [31:0] rdat);
        wb_cycle(1'b0, adr, 32'd0, rdat);
    endtask

    // Model and scoreboard sample on the falling edge
    always @(negedge gated_clk) begin : scoreboard
        logic [16:0] e;
        logic        le;
        if (rst_n) begin
            if (pix_valid && pix_ready) begin
                line_pos++;
                le = (line_pos >= ((model_len == 0) ? 1 : int'(model_len)));
                if (le) begin
                    line_pos = 0;
                    lines_done++;
                end
                exp_q.push_back({le, conv_ref(model_fmt, pix_data)});
                n_accepted++;
            end
            if (out_valid) begin
                n_out++;
                if (exp_q.size() == 0) begin
                    n_other_err++;
                    $display("output at %0t with no accepted pixel pending", $time);
                end else begin
                    e = exp_q.pop_front();
                    if (out_data !== e[15:0]) flag_mismatch("out_data", e[15:0], out_data);
                    if (out_line_end !== e[16]) flag_mismatch("out_line_end", e[16], out_line_end);
                end
            end else if (out_line_end) begin
                n_other_err++;
                $display("out_line_end high without out_valid at %0t", $time);
            end
        end
    end

    task automatic check_table_entry(input int i);
        fmt_t        f;
        logic [31:0] din;
        logic [15:0] dexp;
        logic        taken;
        {f, din, dexp} = stim_table[i];
        wb_write(REG_CTRL, {29'd0, f, 1'b1});
        pix_valid = 1'b1;
        pix_data  = din;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge gated_clk);
            taken = pix_ready;
            @(posedge gated_clk);
            #2;
        end
        pix_valid = 1'b0;
        for (int k = 1; k <= 4; k++) begin
            @(negedge gated_clk);
            if (k < 4 && out_valid) begin
                n_other_err++;
                $display("table entry %0d came out early at %0t", i, $time);
            end else if (k == 4 && !out_valid) begin
                n_other_err++;
                $display("table entry %0d missing 4 cycles after acceptance", i);
            end else if (k == 4 && out_data !== dexp) begin
                flag_mismatch("out_data", dexp, out_data);
            end
        end
        @(posedge gated_clk);
        #2;
    endtask

    // Random source with stalls and a check of the blanking gap on pix_ready
    task automatic stream_pixels(input int n);
        int acc;
        acc        = 0;
        after_last = 1'b0;
        low_run    = 0;
        while (acc < n) begin
            pix_valid = (rand_bits(2) != 0);
            pix_data  = rand_bits(32);
            @(negedge gated_clk);
            if (!pix_ready) begin
                if (!after_last) begin
                    n_other_err++;
                    $display("pix_ready dropped in the middle of a line at %0t", $time);
                end
                low_run++;
            end else begin
                if (after_last && low_run != BLANK_LEN) begin
                    n_other_err++;
                    $display("pix_ready low %0d cycles after line end at %0t", low_run, $time);
                end
                after_last = 1'b0;
                low_run    = 0;
                if (pix_valid) begin
                    acc++;
                    after_last = (acc % LINE_LEN == 0);
                end
            end
            @(posedge gated_clk);
            #2;
        end
        pix_valid = 1'b0;
    endtask

    task automatic check_drained();
        if (exp_q.size() != 0 || n_out != n_accepted) begin
            n_other_err++;
            $display("%0d pixels accepted but %0d came out", n_accepted, n_out);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        pix_valid = 1'b0;
        pix_data  = '0;
        repeat (8) @(posedge gated_clk);
        #2 rst_n = 1'b1;

        // Quiet outputs before enable
        repeat (3) begin
            @(negedge gated_clk);
            if (pix_ready || out_valid || wb_ack || out_line_end) begin
                n_other_err++;
                $display("outputs not idle after reset at %0t", $time);
            end
        end
        @(posedge gated_clk);
        #2;

        wb_write(REG_LINE_LEN, 32'hFFFF_F005);
        wb_read(REG_LINE_LEN, rd);
        if (rd !== 32'd5) flag_mismatch("LINE_LEN", 32'd5, rd);
        wb_write(REG_BLANK_LEN, 32'hABCD_EF03);
        wb_read(REG_BLANK_LEN, rd);
        if (rd !== 32'd3) flag_mismatch("BLANK_LEN", 32'd3, rd);
        wb_write(REG_CTRL, 32'hFFFF_FFF4);   // Format MONO with enable still clear
        wb_read(REG_CTRL, rd);
        if (rd !== 32'd4) flag_mismatch("CTRL", 32'd4, rd);
        wb_write(REG_STATUS, 32'h0000_1234);
        wb_read(REG_STATUS, rd);
        if (rd !== 32'd0) flag_mismatch("STATUS", 32'd0, rd);

        for (int i = 0; i < N_TABLE; i++) begin
            check_table_entry(i);
        end

        stream_pixels(N_LINE_PIX);
        wait_cycles(8);
        wb_read(REG_STATUS, rd);
        if (rd !== (N_TABLE + N_LINE_PIX) / LINE_LEN)
            flag_mismatch("STATUS", (N_TABLE + N_LINE_PIX) / LINE_LEN, rd);

        // Format rewrites while pixels are in flight
        fork
            stream_pixels(N_MIX_PIX);
            repeat (5) begin
                repeat (rand_bits(3) + 1) begin
                    @(posedge gated_clk);
                    #2;
                end
                wb_write(REG_CTRL, (rand_bits(2) << 1) | 32'd1);
            end
        join
        wait_cycles(8);
        check_drained();

        // Clear enable partway into a line
        fork
            begin
                for (int c = 0; c < DIS_CYCLES; c++) begin
                    pix_valid = 1'b1;
                    pix_data  = rand_bits(32);
                    @(negedge gated_clk);
                    if (c >= 25 && pix_ready) begin
                        n_other_err++;
                        $display("pix_ready high after disable at %0t", $time);
                    end
                    @(posedge gated_clk);
                    #2;
                end
                pix_valid = 1'b0;
            end
            begin
                wait_cycles(9);
                wb_write(REG_CTRL, 32'd0);
            end
        join
        wait_cycles(10);
        check_drained();
        if (line_pos != 0) begin
            n_other_err++;
            $display("line left unfinished after disable, %0d pixels in", line_pos);
        end
        wb_read(REG_STATUS, rd);
        if (rd !== lines_done) flag_mismatch("STATUS", lines_done, rd);

        $display("%0d value errors, %0d other errors, %0d pixels in, %0d out",
                 n_val_err, n_other_err, n_accepted, n_out);
        if (n_val_err + n_other_err == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== design/disp_codec_top.sv ====
// Display codec top level joining config slave, line FSM, timer and converter
`timescale 1ns/1ps

module disp_codec_top #(
    parameter int IN_WIDTH  = 32,
    parameter int OUT_WIDTH = 16
) (
    input  logic                 gated_clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  disp_pkg::wb_addr_t   wb_adr,
    input  logic [31:0]          wb_dat_w,
    input  logic                 pix_valid,
    input  logic [IN_WIDTH-1:0]  pix_data,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack,
    output logic                 pix_ready,
    output logic                 out_valid,
    output logic [OUT_WIDTH-1:0] out_data,
    output logic                 out_line_end
);
    import disp_pkg::*;

    logic       enable;
    fmt_t       fmt;
    line_len_t  line_len;
    blank_len_t blank_len;
    line_cnt_t  line_count;
    logic       timer_load, timer_sel_blank, timer_tick, timer_done;
    logic       line_last;
    logic       accept;

    assign accept = pix_valid & pix_ready;  // Pixel transfer strobe

    wb_cfg_regs u_regs (
        .gated_clk (gated_clk),  .rst_n    (rst_n),
        .wb_cyc    (wb_cyc),     .wb_stb   (wb_stb),
        .wb_we     (wb_we),      .wb_adr   (wb_adr),
        .wb_dat_w  (wb_dat_w),   .line_count (line_count),
        .wb_dat_r  (wb_dat_r),   .wb_ack   (wb_ack),
        .enable    (enable),     .fmt      (fmt),
        .line_len  (line_len),   .blank_len (blank_len)
    );

    stream_ctrl_fsm u_fsm (
        .gated_clk  (gated_clk),  .rst_n      (rst_n),
        .enable     (enable),     .pix_valid  (pix_valid),
        .timer_done (timer_done), .pix_ready  (pix_ready),
        .timer_load (timer_load), .timer_sel_blank (timer_sel_blank),
        .timer_tick (timer_tick), .line_last  (line_last)
    );

    line_timer u_timer (
        .gated_clk (gated_clk),  .rst_n     (rst_n),
        .load      (timer_load), .sel_blank (timer_sel_blank),
        .tick      (timer_tick), .line_len  (line_len),
        .blank_len (blank_len),  .line_end  (line_last),
        .done      (timer_done), .line_count (line_count)
    );

    pixel_format_conv #(
        .IN_WIDTH  (IN_WIDTH),
        .OUT_WIDTH (OUT_WIDTH)
    ) u_conv (
        .gated_clk    (gated_clk),    .rst_n       (rst_n),
        .in_valid     (accept),       .in_line_end (line_last),
        .in_data      (pix_data),     .fmt         (fmt),
        .out_valid    (out_valid),    .out_line_end (out_line_end),
        .out_data     (out_data)
    );

endmodule

// ==== design/pixel_format_conv.sv ====
// Four-stage pixel format converter with per-pixel valid, line end and format
`timescale 1ns/1ps

module pixel_format_conv #(
    parameter int IN_WIDTH  = 32,
    parameter int OUT_WIDTH = 16
) (
    input  logic                 gated_clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 in_line_end,
    input  logic [IN_WIDTH-1:0]  in_data,
    input  disp_pkg::fmt_t       fmt,
    output logic                 out_valid,
    output logic                 out_line_end,
    output logic [OUT_WIDTH-1:0] out_data
);
    import disp_pkg::*;

    localparam bit RGB_OK = (IN_WIDTH >= 24) && (OUT_WIDTH >= 16);

    localparam logic [1:0] MODE_RGB  = 2'd0;
    localparam logic [1:0] MODE_MONO = 2'd1;
    localparam logic [1:0] MODE_PASS = 2'd3;

    logic [IN_WIDTH-1:0]  data1, data2;
    fmt_t                 fmt1, fmt2;
    logic                 valid1, valid2, valid3;
    logic                 le1, le2, le3;
    logic [1:0]           mode;
    logic [OUT_WIDTH-1:0] rgb_word;
    logic [OUT_WIDTH-1:0] pass_word;
    logic [OUT_WIDTH-1:0] conv_word;
    logic [OUT_WIDTH-1:0] conv_q;

    // Flags advance every cycle
    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            {valid1, valid2, valid3, out_valid} <= '0;
            {le1, le2, le3, out_line_end}       <= '0;
        end else begin
            {valid1, valid2, valid3, out_valid} <= {in_valid, valid1, valid2, valid3};
            {le1, le2, le3, out_line_end}       <= {in_line_end, le1, le2, le3};
        end
    end

    // Payload only moves with its valid flag
    always_ff @(posedge gated_clk) begin
        if (in_valid) begin
            data1 <= in_data;
            fmt1  <= fmt;    // Format sampled at acceptance
        end
        if (valid1) begin
            data2 <= data1;
            fmt2  <= fmt1;
        end
        if (valid2) conv_q   <= conv_word;
        if (valid3) out_data <= conv_q;
    end

    assign pass_word = data2[IN_WIDTH-1 -: OUT_WIDTH];  // Top bits

    generate
        if (RGB_OK) begin : g_rgb
            // R5 G6 B5 from the upper three bytes, low extras zero
            assign rgb_word = {data2[IN_WIDTH-1 -: 5],
                               data2[IN_WIDTH-9 -: 6],
                               data2[IN_WIDTH-17 -: 5],
                               {(OUT_WIDTH-16){1'b0}}};
        end else begin : g_no_rgb
            assign rgb_word = pass_word;
        end
    endgenerate

    always_comb begin
        case (fmt2)
            FMT_RGB:  mode = RGB_OK ? MODE_RGB : MODE_PASS;
            FMT_MONO: mode = MODE_MONO;
            default:  mode = MODE_PASS;  // YUV and RAW
        endcase
    end

    always_comb begin
        case (mode)
            MODE_RGB:  conv_word = rgb_word;
            MODE_MONO: conv_word = {OUT_WIDTH{data2[IN_WIDTH-1]}};
            default:   conv_word = pass_word;
        endcase
    end

endmodule

// ==== design/stream_ctrl_fsm.sv ====
// Line sequencing FSM for pixel acceptance, timer control and line end flag
`timescale 1ns/1ps

module stream_ctrl_fsm (
    input  logic gated_clk,
    input  logic rst_n,
    input  logic enable,
    input  logic pix_valid,
    input  logic timer_done,
    output logic pix_ready,
    output logic timer_load,
    output logic timer_sel_blank,
    output logic timer_tick,
    output logic line_last
);
    import disp_pkg::*;

    stream_state_t state;
    stream_state_t state_next;
    logic          accept;

    assign pix_ready = (state == ST_ACTIVE);
    assign accept    = pix_valid & pix_ready;

    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next      = state;
        timer_load      = 1'b0;
        timer_sel_blank = 1'b0;
        timer_tick      = 1'b0;
        line_last       = 1'b0;
        case (state)
            ST_IDLE: begin
                if (enable) begin
                    timer_load = 1'b1;  // Arm for a full line
                    state_next = ST_ACTIVE;
                end
            end
            ST_ACTIVE: begin
                // Enable is not checked here so the line always completes
                if (accept && timer_done) begin
                    line_last       = 1'b1;
                    timer_load      = 1'b1;
                    timer_sel_blank = 1'b1;
                    state_next      = ST_BLANK;
                end else if (accept) begin
                    timer_tick = 1'b1;
                end
            end
            ST_BLANK: begin
                if (timer_done) begin
                    if (enable) begin
                        timer_load = 1'b1;
                        state_next = ST_ACTIVE;
                    end else begin
                        state_next = ST_IDLE;
                    end
                end else begin
                    timer_tick = 1'b1;  // One per blanking cycle
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

endmodule

// ==== design/line_timer.sv ====
// Shared line and blanking down-counter with completed line counter
`timescale 1ns/1ps

module line_timer (
    input  logic                  gated_clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  logic                  sel_blank,
    input  logic                  tick,
    input  disp_pkg::line_len_t   line_len,
    input  disp_pkg::blank_len_t  blank_len,
    input  logic                  line_end,
    output logic                  done,
    output disp_pkg::line_cnt_t   line_count
);
    import disp_pkg::*;

    line_len_t cnt;
    line_len_t limit;
    line_len_t load_val;

    // Blanking length widened to the counter
    assign limit = sel_blank ? line_len_t'(blank_len) : line_len;

    // Zero limit behaves as one
    assign load_val = (limit == '0) ? '0 : limit - 1'b1;

    assign done = (cnt == '0);

    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= load_val;  // Load wins over tick
        end else if (tick && !done) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Counts on the accepting edge of each last pixel
    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            line_count <= '0;
        end else if (line_end) begin
            line_count <= line_count + 1'b1;
        end
    end

endmodule

// ==== design/wb_cfg_regs.sv ====
// Wishbone classic configuration slave with control, line, blanking and status registers
`timescale 1ns/1ps

module wb_cfg_regs (
    input  logic                  gated_clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  disp_pkg::wb_addr_t    wb_adr,
    input  logic [31:0]           wb_dat_w,
    input  disp_pkg::line_cnt_t   line_count,
    output logic [31:0]           wb_dat_r,
    output logic                  wb_ack,
    output logic                  enable,
    output disp_pkg::fmt_t        fmt,
    output disp_pkg::line_len_t   line_len,
    output disp_pkg::blank_len_t  blank_len
);
    import disp_pkg::*;

    logic        req;
    logic        acked;    // This strobe already got its ack
    logic        ack_next;
    logic [31:0] rd_word;

    assign req      = wb_cyc & wb_stb;
    assign ack_next = req & ~wb_ack & ~acked;

    // One ack per strobe, held off until stb drops
    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            acked  <= 1'b0;
        end else begin
            wb_ack <= ack_next;
            acked  <= req & (acked | wb_ack);
        end
    end

    // Writes land on the edge that raises ack
    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            enable    <= 1'b0;
            fmt       <= FMT_RGB;
            line_len  <= '0;
            blank_len <= '0;
        end else if (ack_next && wb_we) begin
            case (wb_adr)
                REG_CTRL: begin
                    enable <= wb_dat_w[CTRL_EN_BIT];
                    fmt    <= wb_dat_w[CTRL_FMT_LSB +: 2];
                end
                REG_LINE_LEN:  line_len  <= wb_dat_w[11:0];
                REG_BLANK_LEN: blank_len <= wb_dat_w[7:0];
                default: ;  // STATUS ignores writes
            endcase
        end
    end

    // Read mux
    always_comb begin
        rd_word = '0;
        case (wb_adr)
            REG_CTRL: begin
                rd_word[CTRL_EN_BIT]      = enable;
                rd_word[CTRL_FMT_LSB +: 2] = fmt;
            end
            REG_LINE_LEN:  rd_word[11:0] = line_len;
            REG_BLANK_LEN: rd_word[7:0]  = blank_len;
            default:       rd_word[15:0] = line_count;
        endcase
    end

    // Read data held alongside ack
    always_ff @(posedge gated_clk) begin
        if (ack_next && !wb_we) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

// ==== design/disp_pkg.sv ====
// Shared format codes, register indices, width types and stream FSM states
package disp_pkg;

    // Pixel format code carried with every pixel
    typedef logic [1:0] fmt_t;

    localparam fmt_t FMT_RGB  = 2'd0;
    localparam fmt_t FMT_YUV  = 2'd1;
    localparam fmt_t FMT_MONO = 2'd2;
    localparam fmt_t FMT_RAW  = 2'd3;

    typedef logic [11:0] line_len_t;   // Pixels per line
    typedef logic [7:0]  blank_len_t;  // Blanking cycles
    typedef logic [15:0] line_cnt_t;   // Completed lines, wraps

    // Word index, address bits 3..2
    typedef logic [1:0] wb_addr_t;

    localparam wb_addr_t REG_CTRL      = 2'd0;  // [0] enable, [2:1] format
    localparam wb_addr_t REG_LINE_LEN  = 2'd1;
    localparam wb_addr_t REG_BLANK_LEN = 2'd2;
    localparam wb_addr_t REG_STATUS    = 2'd3;  // Read only

    // Bit positions inside CTRL
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_FMT_LSB = 1;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,  // Not running
        ST_ACTIVE = 2'd1,  // Accepting pixels
        ST_BLANK  = 2'd2   // Waiting out blanking
    } stream_state_t;

endpackage
